// ==== hdl/exe_pkg.sv ====
/* execute unit shared definitions
 * command codes, operand and result widths, and the result word union
 */
`default_nettype none

package exe_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int OPERAND_W = 16;           // src and dst operands
    localparam int RESULT_W  = 32;           // result word toward writeback
    localparam int DIV_ITER  = OPERAND_W;    // one quotient bit per iteration

    // ----------------------------------------
    // command codes
    // ----------------------------------------
    typedef enum logic [2:0] {
        CMD_NULL = 3'd0,                     // latch empty
        CMD_SHL  = 3'd1,
        CMD_SHR  = 3'd2,
        CMD_ROL  = 3'd3,
        CMD_MUL  = 3'd4,
        CMD_DIV  = 3'd5
    } exe_cmd_e;

    // ----------------------------------------
    // result word
    // ----------------------------------------
    typedef struct packed {
        logic [OPERAND_W-1:0] remainder;     // upper half
        logic [OPERAND_W-1:0] quotient;      // lower half
    } exe_div_result_t;

    // divide fills both halves, the other units fill one plain value
    typedef union packed {
        logic [RESULT_W-1:0] word;
        exe_div_result_t     div;
    } exe_result_t;

endpackage

`default_nettype wire

// ==== hdl/exe_issue.sv ====
/* execute issue stage
 * one-entry command latch, writeback credit counter and unit dispatch
 */
`default_nettype none

module exe_issue #(
    parameter int CREDITS = 4,
    parameter int TAG_W   = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cmd_valid,
    input  exe_pkg::exe_cmd_e             cmd,
    input  logic [TAG_W-1:0]              cmd_tag,
    input  logic [exe_pkg::OPERAND_W-1:0] src,
    input  logic [exe_pkg::OPERAND_W-1:0] dst,
    input  logic                          credit_return,
    input  logic                          shift_ready,
    input  logic                          mult_ready,
    input  logic                          div_ready,
    output logic                          exe_busy,
    output logic                          shift_start,
    output logic                          mult_start,
    output logic                          div_start,
    output exe_pkg::exe_cmd_e             op_cmd,
    output logic [TAG_W-1:0]              op_tag,
    output logic [exe_pkg::OPERAND_W-1:0] op_src,
    output logic [exe_pkg::OPERAND_W-1:0] op_dst
);
    import exe_pkg::*;

    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;
    logic             is_shift;
    logic             unit_ready;
    logic             dispatch;
    logic             load;

    // ----------------------------------------
    // dispatch decision
    // ----------------------------------------
    assign is_shift = (op_cmd == CMD_SHL) || (op_cmd == CMD_SHR) || (op_cmd == CMD_ROL);

    always_comb begin
        case (op_cmd)
            CMD_SHL, CMD_SHR, CMD_ROL: unit_ready = shift_ready;
            CMD_MUL:                   unit_ready = mult_ready;
            CMD_DIV:                   unit_ready = div_ready;
            default:                   unit_ready = 1'b0;   // empty latch
        endcase
    end

    assign dispatch    = unit_ready && (credit_cnt != '0);
    assign exe_busy    = (op_cmd != CMD_NULL) && !dispatch;   // freed in the dispatch cycle
    assign load        = cmd_valid && !exe_busy;
    assign shift_start = dispatch && is_shift;
    assign mult_start  = dispatch && (op_cmd == CMD_MUL);
    assign div_start   = dispatch && (op_cmd == CMD_DIV);

    // ----------------------------------------
    // command latch
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_cmd <= CMD_NULL;
        end else if (load) begin
            op_cmd <= cmd;
        end else if (dispatch) begin
            op_cmd <= CMD_NULL;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            op_tag <= cmd_tag;
            op_src <= src;
            op_dst <= dst;
        end
    end

    // one credit per free result slot at writeback
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= CNT_W'(CREDITS);
        end else begin
            credit_cnt <= credit_cnt - CNT_W'(dispatch) + CNT_W'(credit_return);
        end
    end

    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= CNT_W'(CREDITS));

    a_credit_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(credit_return && credit_cnt == CNT_W'(CREDITS)));

endmodule

`default_nettype wire

// ==== hdl/exe_shift.sv ====
/* shift and rotate unit
 * combinational SHL, SHR and ROL with a one-entry result hold
 */
`default_nettype none

module exe_shift #(
    parameter int TAG_W = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  exe_pkg::exe_cmd_e             cmd,
    input  logic [TAG_W-1:0]              tag,
    input  logic [exe_pkg::OPERAND_W-1:0] src,
    input  logic [exe_pkg::OPERAND_W-1:0] dst,
    output logic                          ready,
    output logic                          req,
    output logic [TAG_W-1:0]              res_tag,
    output exe_pkg::exe_result_t          res,
    input  logic                          grant
);
    import exe_pkg::*;

    logic [3:0]             cnt;
    logic [OPERAND_W:0]     shl_ext;    // carry above the value
    logic [OPERAND_W:0]     shr_ext;    // carry below the value
    logic [2*OPERAND_W-1:0] rol_ext;
    logic [OPERAND_W-1:0]   value;
    logic                   carry;

    assign cnt = src[3:0];

    always_comb begin
        shl_ext = {1'b0, dst} << cnt;
        shr_ext = {dst, 1'b0} >> cnt;
        rol_ext = {dst, dst} << cnt;
        value   = '0;
        carry   = 1'b0;
        case (cmd)
            CMD_SHL: begin
                value = shl_ext[OPERAND_W-1:0];
                carry = shl_ext[OPERAND_W];          // 0 for a zero count
            end
            CMD_SHR: begin
                value = shr_ext[OPERAND_W:1];
                carry = shr_ext[0];
            end
            CMD_ROL: begin
                value = rol_ext[2*OPERAND_W-1:OPERAND_W];
                carry = (cnt != 4'd0) && rol_ext[OPERAND_W];   // new bit 0
            end
            default: ;
        endcase
    end

    assign ready = !req || grant;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req <= 1'b0;
        end else if (start) begin
            req <= 1'b1;
        end else if (grant) begin
            req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            res_tag  <= tag;
            res.word <= {{(RESULT_W-OPERAND_W-1){1'b0}}, carry, value};
        end
    end

endmodule

`default_nettype wire

// ==== hdl/exe_multiply.sv ====
/* unsigned 16x16 multiplier
 * MULT_STAGES deep, the last stage doubles as the output hold
 */
`default_nettype none

module exe_multiply #(
    parameter int TAG_W       = 4,
    parameter int MULT_STAGES = 2
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic [TAG_W-1:0]              tag,
    input  logic [exe_pkg::OPERAND_W-1:0] src,
    input  logic [exe_pkg::OPERAND_W-1:0] dst,
    output logic                          ready,
    output logic                          req,
    output logic [TAG_W-1:0]              res_tag,
    output exe_pkg::exe_result_t          res,
    input  logic                          grant
);
    import exe_pkg::*;

    localparam int LAST = MULT_STAGES - 1;

    logic [MULT_STAGES-1:0] stg_valid;
    logic [TAG_W-1:0]       stg_tag  [MULT_STAGES];
    logic [RESULT_W-1:0]    stg_prod [MULT_STAGES];
    logic                   advance;

    assign advance = !stg_valid[LAST] || grant;   // whole pipe stalls on a held result
    assign ready   = advance;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stg_valid <= '0;
        end else if (advance) begin
            stg_valid[0] <= start;
            for (int i = 1; i < MULT_STAGES; i++) begin
                stg_valid[i] <= stg_valid[i-1];
            end
        end
    end

    // later stages give synthesis room to retime the product
    always_ff @(posedge clk) begin
        if (advance) begin
            stg_tag[0]  <= tag;
            stg_prod[0] <= RESULT_W'(src) * RESULT_W'(dst);
            for (int i = 1; i < MULT_STAGES; i++) begin
                stg_tag[i]  <= stg_tag[i-1];
                stg_prod[i] <= stg_prod[i-1];
            end
        end
    end

    assign req      = stg_valid[LAST];
    assign res_tag  = stg_tag[LAST];
    assign res.word = stg_prod[LAST];

    a_start_ready: assert property (@(posedge clk) disable iff (!rst_n) start |-> ready);

endmodule

`default_nettype wire

// ==== hdl/exe_divide.sv ====
/* iterative restoring divider
 * dst / src, one quotient bit per cycle, zero divisor raises the fault
 */
`default_nettype none

module exe_divide #(
    parameter int TAG_W = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic [TAG_W-1:0]              tag,
    input  logic [exe_pkg::OPERAND_W-1:0] src,
    input  logic [exe_pkg::OPERAND_W-1:0] dst,
    output logic                          ready,
    output logic                          req,
    output logic [TAG_W-1:0]              res_tag,
    output exe_pkg::exe_result_t          res,
    output logic                          fault,
    input  logic                          grant
);
    import exe_pkg::*;

    localparam int ITER_W = $clog2(DIV_ITER + 1);

    logic                 run;
    logic [ITER_W-1:0]    iter_cnt;
    logic [OPERAND_W-1:0] divisor;
    logic [OPERAND_W-1:0] rem_q;
    logic [OPERAND_W-1:0] quo_q;     // dividend shifts out, quotient shifts in
    logic [OPERAND_W:0]   shifted;
    logic [OPERAND_W:0]   diff;
    logic                 div_zero;
    logic                 last_iter;

    // ----------------------------------------
    // restoring step
    // ----------------------------------------
    assign div_zero  = (src == '0);
    assign shifted   = {rem_q, quo_q[OPERAND_W-1]};
    assign diff      = shifted - {1'b0, divisor};   // msb set means restore
    assign last_iter = (iter_cnt == ITER_W'(DIV_ITER - 1));

    assign ready              = !run && (!req || grant);
    assign res.div.remainder  = rem_q;
    assign res.div.quotient   = quo_q;

    // ----------------------------------------
    // control
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run      <= 1'b0;
            req      <= 1'b0;
            iter_cnt <= '0;
        end else if (start) begin
            run      <= !div_zero;
            req      <= div_zero;              // zero divisor skips the loop
            iter_cnt <= '0;
        end else if (run) begin
            iter_cnt <= iter_cnt + 1'b1;
            if (last_iter) begin
                run <= 1'b0;
                req <= 1'b1;
            end
        end else if (grant) begin
            req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            res_tag <= tag;
            divisor <= src;
            rem_q   <= '0;
            quo_q   <= div_zero ? '0 : dst;
            fault   <= div_zero;
        end else if (run) begin
            rem_q <= diff[OPERAND_W] ? shifted[OPERAND_W-1:0] : diff[OPERAND_W-1:0];
            quo_q <= {quo_q[OPERAND_W-2:0], ~diff[OPERAND_W]};
        end
    end

    a_iter_bound: assert property (@(posedge clk) disable iff (!rst_n)
        iter_cnt <= ITER_W'(DIV_ITER));

endmodule

`default_nettype wire

// ==== hdl/exe_result_arbiter.sv ====
/* result bus arbiter
 * fixed priority divide, multiply, shift onto the writeback bus
 */
`default_nettype none

module exe_result_arbiter #(
    parameter int TAG_W = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 shift_req,
    input  logic [TAG_W-1:0]     shift_tag,
    input  exe_pkg::exe_result_t shift_res,
    input  logic                 shift_fault,
    input  logic                 mult_req,
    input  logic [TAG_W-1:0]     mult_tag,
    input  exe_pkg::exe_result_t mult_res,
    input  logic                 mult_fault,
    input  logic                 div_req,
    input  logic [TAG_W-1:0]     div_tag,
    input  exe_pkg::exe_result_t div_res,
    input  logic                 div_fault,
    output logic                 shift_grant,
    output logic                 mult_grant,
    output logic                 div_grant,
    output logic                 result_valid,
    output logic [TAG_W-1:0]     result_tag,
    output exe_pkg::exe_result_t result,
    output logic                 result_div_fault
);
    import exe_pkg::*;

    assign div_grant    = div_req;
    assign mult_grant   = mult_req && !div_req;
    assign shift_grant  = shift_req && !div_req && !mult_req;
    assign result_valid = div_req || mult_req || shift_req;   // same cycle as the grant

    always_comb begin
        result_tag       = '0;
        result           = '0;
        result_div_fault = 1'b0;
        if (div_grant) begin
            result_tag       = div_tag;
            result           = div_res;
            result_div_fault = div_fault;
        end else if (mult_grant) begin
            result_tag       = mult_tag;
            result           = mult_res;
            result_div_fault = mult_fault;
        end else if (shift_grant) begin
            result_tag       = shift_tag;
            result           = shift_res;
            result_div_fault = shift_fault;
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({div_grant, mult_grant, shift_grant}));

    a_grant_req: assert property (@(posedge clk) disable iff (!rst_n)
        (!div_grant || div_req) && (!mult_grant || mult_req) && (!shift_grant || shift_req));

endmodule

`default_nettype wire

// ==== hdl/exe_top.sv ====
/* 16-bit execute unit
 * issue latch, shift, multiply and divide units sharing one result bus
 */
`default_nettype none

module exe_top #(
    parameter int CREDITS     = 4,
    parameter int TAG_W       = 4,
    parameter int MULT_STAGES = 2
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cmd_valid,
    input  exe_pkg::exe_cmd_e             cmd,
    input  logic [TAG_W-1:0]              cmd_tag,
    input  logic [exe_pkg::OPERAND_W-1:0] src,
    input  logic [exe_pkg::OPERAND_W-1:0] dst,
    input  logic                          credit_return,
    output logic                          exe_busy,
    output logic                          result_valid,
    output logic [TAG_W-1:0]              result_tag,
    output exe_pkg::exe_result_t          result,
    output logic                          result_div_fault
);
    import exe_pkg::*;

    exe_cmd_e             op_cmd;
    logic [TAG_W-1:0]     op_tag;
    logic [OPERAND_W-1:0] op_src;
    logic [OPERAND_W-1:0] op_dst;

    logic                 shift_start, shift_ready, shift_req, shift_grant;
    logic [TAG_W-1:0]     shift_tag;
    exe_result_t          shift_res;
    logic                 mult_start, mult_ready, mult_req, mult_grant;
    logic [TAG_W-1:0]     mult_tag;
    exe_result_t          mult_res;
    logic                 div_start, div_ready, div_req, div_grant, div_fault;
    logic [TAG_W-1:0]     div_tag;
    exe_result_t          div_res;

    // ----------------------------------------
    // issue
    // ----------------------------------------
    exe_issue #(.CREDITS(CREDITS), .TAG_W(TAG_W)) u_issue (
        .clk, .rst_n, .cmd_valid, .cmd, .cmd_tag, .src, .dst, .credit_return,
        .shift_ready, .mult_ready, .div_ready, .exe_busy,
        .shift_start, .mult_start, .div_start,
        .op_cmd, .op_tag, .op_src, .op_dst
    );

    // ----------------------------------------
    // units
    // ----------------------------------------
    exe_shift #(.TAG_W(TAG_W)) u_shift (
        .clk, .rst_n, .start(shift_start), .cmd(op_cmd), .tag(op_tag),
        .src(op_src), .dst(op_dst), .ready(shift_ready), .req(shift_req),
        .res_tag(shift_tag), .res(shift_res), .grant(shift_grant)
    );

    exe_multiply #(.TAG_W(TAG_W), .MULT_STAGES(MULT_STAGES)) u_multiply (
        .clk, .rst_n, .start(mult_start), .tag(op_tag),
        .src(op_src), .dst(op_dst), .ready(mult_ready), .req(mult_req),
        .res_tag(mult_tag), .res(mult_res), .grant(mult_grant)
    );

    exe_divide #(.TAG_W(TAG_W)) u_divide (
        .clk, .rst_n, .start(div_start), .tag(op_tag),
        .src(op_src), .dst(op_dst), .ready(div_ready), .req(div_req),
        .res_tag(div_tag), .res(div_res), .fault(div_fault), .grant(div_grant)
    );

    // ----------------------------------------
    // writeback bus
    // ----------------------------------------
    exe_result_arbiter #(.TAG_W(TAG_W)) u_arbiter (
        .clk, .rst_n,
        .shift_req, .shift_tag, .shift_res, .shift_fault(1'b0),   // shifts never fault
        .mult_req, .mult_tag, .mult_res, .mult_fault(1'b0),
        .div_req, .div_tag, .div_res, .div_fault,
        .shift_grant, .mult_grant, .div_grant,
        .result_valid, .result_tag, .result, .result_div_fault
    );

endmodule

`default_nettype wire

// ==== tests/exe_tb.sv ====
/* execute unit testbench
 * directed tests against a tag-indexed scoreboard with writeback credit returns
 */
`default_nettype none

module exe_tb;
    import exe_pkg::*;

    localparam int CREDITS        = 4;
    localparam int TAG_W          = 5;      // enough tags that the burst never reuses one
    localparam int MULT_STAGES    = 2;
    localparam int NUM_TAGS       = 1 << TAG_W;
    localparam int TIMEOUT_CYCLES = 3000;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 cmd_valid;
    exe_cmd_e             cmd;
    logic [TAG_W-1:0]     cmd_tag;
    logic [OPERAND_W-1:0] src;
    logic [OPERAND_W-1:0] dst;
    logic                 credit_return = 1'b0;
    logic                 exe_busy;
    logic                 result_valid;
    logic [TAG_W-1:0]     result_tag;
    exe_result_t          result;
    logic                 result_div_fault;

    // a tag is in flight while its two scoreboard flags differ
    exe_result_t exp_res    [NUM_TAGS];
    logic        exp_fault  [NUM_TAGS];
    bit          issue_flag [NUM_TAGS];
    bit          done_flag  [NUM_TAGS];
    int          issued;
    int          results_seen;
    int          owed_credits;
    bit          returns_on;
    int          cycle_cnt;
    integer      seed = 32'he711;

    exe_top #(.CREDITS(CREDITS), .TAG_W(TAG_W), .MULT_STAGES(MULT_STAGES)) UUT (
        .clk, .rst_n, .cmd_valid, .cmd, .cmd_tag, .src, .dst, .credit_return,
        .exe_busy, .result_valid, .result_tag, .result, .result_div_fault
    );

    always #5 clk = ~clk;

    // ----------------------------------------
    // error reporting
    // ----------------------------------------
    task automatic value_error(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, expected);
        $display("ERRORS FOUND");
        $fatal(1, "wrong value on the DUT outputs");
    endtask

    task automatic abort_run(input string why);
        $display("ERRORS FOUND");
        $fatal(1, "%s", why);
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic exe_result_t model_result(input exe_cmd_e c, input logic [15:0] s,
                                                 input logic [15:0] d);
        exe_result_t r;
        logic [15:0] v;
        logic        carry;
        int          n;
        r     = '0;
        v     = d;
        carry = 1'b0;
        n     = 32'(s[3:0]);
        case (c)
            CMD_SHL, CMD_SHR, CMD_ROL: begin
                for (int i = 0; i < n; i++) begin    // one bit position per step
                    if (c == CMD_SHL) begin
                        carry = v[15];
                        v     = {v[14:0], 1'b0};
                    end else if (c == CMD_SHR) begin
                        carry = v[0];
                        v     = {1'b0, v[15:1]};
                    end else begin
                        v     = {v[14:0], v[15]};
                        carry = v[0];
                    end
                end
                r.word = {15'd0, carry, v};
            end
            CMD_MUL: r.word = {16'd0, d} * {16'd0, s};
            CMD_DIV: begin
                if (s != 16'h0000) begin              // zero divisor leaves a zero word
                    r.div.quotient  = d / s;
                    r.div.remainder = d % s;
                end
            end
            default: ;
        endcase
        return r;
    endfunction

    function automatic logic [15:0] rand16();
        return 16'($random(seed));
    endfunction

    // ----------------------------------------
    // command driving
    // ----------------------------------------
    task automatic post_cmd(input exe_cmd_e c, input logic [TAG_W-1:0] t,
                            input logic [15:0] s, input logic [15:0] d);
        assert (issue_flag[t] == done_flag[t])
            else abort_run("a tag was issued again while its result was still outstanding");
        exp_res[t]    = model_result(c, s, d);
        exp_fault[t]  = (c == CMD_DIV) && (s == 16'h0000);
        issue_flag[t] = ~issue_flag[t];
        issued        = issued + 1;
        cmd_valid     = 1'b1;
        cmd           = c;
        cmd_tag       = t;
        src           = s;
        dst           = d;
    endtask

    task automatic wait_accept();
        while (exe_busy) @(negedge clk);
        @(negedge clk);                              // taken on the edge just passed
        cmd_valid = 1'b0;
    endtask

    task automatic issue_cmd(input exe_cmd_e c, input logic [TAG_W-1:0] t,
                             input logic [15:0] s, input logic [15:0] d);
        post_cmd(c, t, s, d);
        wait_accept();
    endtask

    task automatic drain_results();
        while (issued != results_seen || owed_credits != 0) @(negedge clk);
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic after_reset();
        assert (!exe_busy) else value_error("exe_busy after reset", 32'(exe_busy), 32'd0);
        assert (!result_valid)
            else value_error("result_valid after reset", 32'(result_valid), 32'd0);
    endtask

    task automatic shift_cases();
        exe_cmd_e    ops [3];
        int          counts [4];
        logic [15:0] s;
        ops    = '{CMD_SHL, CMD_SHR, CMD_ROL};
        counts = '{0, 1, 7, 15};
        for (int o = 0; o < 3; o++) begin
            for (int k = 0; k < 4; k++) begin
                s      = rand16();
                s[3:0] = 4'(counts[k]);              // upper bits are don't care
                issue_cmd(ops[o], TAG_W'(o * 4 + k), s, rand16());
            end
        end
        drain_results();
    endtask

    task automatic multiply_cases();
        issue_cmd(CMD_MUL, TAG_W'(0), 16'hffff, 16'hffff);
        issue_cmd(CMD_MUL, TAG_W'(1), 16'h0000, 16'h1234);
        issue_cmd(CMD_MUL, TAG_W'(2), 16'h0003, 16'h0005);
        drain_results();
        for (int i = 0; i < 4; i++) begin           // back to back with their own tags
            issue_cmd(CMD_MUL, TAG_W'(8 + i), rand16(), rand16());
        end
        drain_results();
    endtask

    task automatic divide_cases();
        logic [15:0] s;
        for (int i = 0; i < 6; i++) begin
            s = rand16();
            if (i >= 3) begin
                s[15:8] = 8'h00;                     // small divisor for a wide quotient
            end
            issue_cmd(CMD_DIV, TAG_W'(i), s, rand16());
        end
        issue_cmd(CMD_DIV, TAG_W'(6), 16'h0000, rand16());
        issue_cmd(CMD_DIV, TAG_W'(7), 16'd7, 16'd100);
        drain_results();
    endtask

    task automatic credit_backpressure();
        int base;
        base       = results_seen;
        returns_on = 1'b0;
        for (int i = 0; i <= CREDITS; i++) begin     // the last one waits in the latch
            issue_cmd(CMD_MUL, TAG_W'(i), rand16(), rand16());
        end
        post_cmd(CMD_MUL, TAG_W'(CREDITS + 1), rand16(), rand16());
        while (results_seen - base < CREDITS) @(posedge clk);
        repeat (50) begin
            @(negedge clk);
            assert (exe_busy) else abort_run("exe_busy dropped although no credit was free");
        end
        @(posedge clk);
        assert (results_seen - base == CREDITS)
            else value_error("results without credit return", 32'(results_seen - base),
                             32'(CREDITS));
        @(negedge clk);
        returns_on = 1'b1;
        wait_accept();
        drain_results();
    endtask

    task automatic mixed_burst();
        exe_cmd_e ops [5];
        int       pick;
        ops = '{CMD_SHL, CMD_SHR, CMD_ROL, CMD_MUL, CMD_DIV};
        for (int i = 0; i < 20; i++) begin
            pick = $unsigned($random(seed)) % 5;
            if (i < 5) begin
                pick = i;                            // every type at least once
            end
            issue_cmd(ops[pick], TAG_W'(i), rand16(), rand16());
        end
        drain_results();
    endtask

    // ----------------------------------------
    // result monitor and credit return
    // ----------------------------------------
    always @(negedge clk) begin
        if (rst_n && result_valid) begin
            assert (issue_flag[result_tag] != done_flag[result_tag])
                else abort_run("a result came back for a tag with no command in flight");
            assert (result.word == exp_res[result_tag].word)
                else value_error($sformatf("result word of tag %0d", result_tag),
                                 result.word, exp_res[result_tag].word);
            assert (result_div_fault == exp_fault[result_tag])
                else value_error($sformatf("divide fault of tag %0d", result_tag),
                                 32'(result_div_fault), 32'(exp_fault[result_tag]));
            done_flag[result_tag] = ~done_flag[result_tag];
            results_seen          = results_seen + 1;
            owed_credits          = owed_credits + 1;
        end
        if (returns_on && owed_credits > 0) begin   // one slot freed per cycle
            credit_return = 1'b1;
            owed_credits  = owed_credits - 1;
        end else begin
            credit_return = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run("timeout, the tests did not finish within the cycle limit");
        end
    end

    initial begin
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = CMD_NULL;
        cmd_tag    = '0;
        src        = '0;
        dst        = '0;
        returns_on = 1'b1;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        after_reset();
        shift_cases();
        multiply_cases();
        divide_cases();
        credit_backpressure();
        mixed_burst();
        drain_results();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/exe_pkg.sv
hdl/exe_issue.sv
hdl/exe_shift.sv
hdl/exe_multiply.sv
hdl/exe_divide.sv
hdl/exe_result_arbiter.sv
hdl/exe_top.sv
tests/exe_tb.sv

// ==== Makefile ====
# Verilator build for the execute unit testbench

VERILATOR ?= verilator
TOP       ?= exe_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
